/* common/rv_isa_pkg.sv */
package rv_isa_pkg;

    // major opcode field, inst[6:0]
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } rv_opcode_e;

    // alu operation, chosen by decode
    // branches use sub for eq/ne, slt/sltu for the compares
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_slt  = 4'd5,
        alu_sltu = 4'd6,
        alu_sll  = 4'd7,
        alu_srl  = 4'd8,
        alu_sra  = 4'd9
    } alu_op_e;

    // func3 of conditional branches
    typedef enum logic [2:0] {
        br_beq  = 3'b000,
        br_bne  = 3'b001,
        br_blt  = 3'b100,
        br_bge  = 3'b101,
        br_bltu = 3'b110,
        br_bgeu = 3'b111
    } branch_cond_e;

endpackage

/* common/ex_pipe_pkg.sv */
package ex_pipe_pkg;

    // architectural register index, x0..x31
    typedef logic [4:0] reg_idx_t;

    // where a source operand is taken from
    // ex_lsu wins over lsu_wb, regfile is the fallback
    typedef enum logic [1:0] {
        fwd_regfile = 2'd0,
        fwd_ex_lsu  = 2'd1,
        fwd_lsu_wb  = 2'd2
    } fwd_src_e;

endpackage

/* ex_stage/operand_forward.sv */
module operand_forward #(
    parameter int XLEN = 32
) (
    input  ex_pipe_pkg::reg_idx_t id_rs1,
    input  ex_pipe_pkg::reg_idx_t id_rs2,
    input  logic [XLEN-1:0]       rf_rs1_data,
    input  logic [XLEN-1:0]       rf_rs2_data,
    // execute/memory register, fed back
    input  logic                  ex_lsu_valid,
    input  logic                  ex_lsu_reg_write,
    input  logic                  ex_lsu_mem_read,
    input  ex_pipe_pkg::reg_idx_t ex_lsu_rd,
    input  logic [XLEN-1:0]       ex_lsu_result,
    // write-back path
    input  logic                  lsu_wb_valid,
    input  logic                  lsu_wb_reg_write,
    input  ex_pipe_pkg::reg_idx_t lsu_wb_rd,
    input  logic [XLEN-1:0]       lsu_wb_data,
    // load still in flight in memory stage
    input  logic                  lsu_load_pending,
    input  ex_pipe_pkg::reg_idx_t lsu_load_rd,
    output logic [XLEN-1:0]       src1,
    output logic [XLEN-1:0]       src2,
    output logic                  load_use
);

    logic ex_fwd_ok;
    logic wb_fwd_ok;
    logic ex_load;
    logic pend_load;
    ex_pipe_pkg::fwd_src_e sel1;
    ex_pipe_pkg::fwd_src_e sel2;

    // ex_lsu result usable only for non-loads, data not there yet otherwise
    assign ex_fwd_ok = ex_lsu_valid && ex_lsu_reg_write && !ex_lsu_mem_read
                       && (ex_lsu_rd != '0);
    assign wb_fwd_ok = lsu_wb_valid && lsu_wb_reg_write && (lsu_wb_rd != '0);

    // priority select for one source index
    function automatic ex_pipe_pkg::fwd_src_e pick_src(input ex_pipe_pkg::reg_idx_t idx);
        ex_pipe_pkg::fwd_src_e sel;
        sel = ex_pipe_pkg::fwd_regfile;
        if (ex_fwd_ok && (ex_lsu_rd == idx)) begin
            sel = ex_pipe_pkg::fwd_ex_lsu;
        end else if (wb_fwd_ok && (lsu_wb_rd == idx)) begin
            sel = ex_pipe_pkg::fwd_lsu_wb;
        end
        return sel;
    endfunction

    assign sel1 = pick_src(id_rs1);
    assign sel2 = pick_src(id_rs2);

    always_comb begin
        case (sel1)
            ex_pipe_pkg::fwd_ex_lsu: src1 = ex_lsu_result;
            ex_pipe_pkg::fwd_lsu_wb: src1 = lsu_wb_data;
            default:                 src1 = rf_rs1_data;
        endcase
        case (sel2)
            ex_pipe_pkg::fwd_ex_lsu: src2 = ex_lsu_result;
            ex_pipe_pkg::fwd_lsu_wb: src2 = lsu_wb_data;
            default:                 src2 = rf_rs2_data;
        endcase
    end

    // load one ahead, or load still waiting on memory
    assign ex_load   = ex_lsu_valid && ex_lsu_mem_read && (ex_lsu_rd != '0)
                       && ((ex_lsu_rd == id_rs1) || (ex_lsu_rd == id_rs2));
    assign pend_load = lsu_load_pending && (lsu_load_rd != '0)
                       && ((lsu_load_rd == id_rs1) || (lsu_load_rd == id_rs2));
    assign load_use  = ex_load || pend_load;

endmodule

/* ex_stage/alu.sv */
module alu #(
    parameter int XLEN = 32
) (
    input  rv_isa_pkg::rv_opcode_e id_opcode,
    input  rv_isa_pkg::alu_op_e    id_alu_op,
    input  logic [XLEN-1:0]        id_pc,
    input  logic [XLEN-1:0]        id_imm,
    input  logic [XLEN-1:0]        src1,
    input  logic [XLEN-1:0]        src2,
    output logic [XLEN-1:0]        alu_result,
    output logic                   alu_zero,
    output logic                   alu_less
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic            lt_signed;
    logic            lt_unsigned;

    // operand select by instruction form
    always_comb begin
        op_a = src1;
        op_b = src2;
        case (id_opcode)
            rv_isa_pkg::op_load, rv_isa_pkg::op_store: begin
                // effective address
                op_b = id_imm;
            end
            rv_isa_pkg::op_jal, rv_isa_pkg::op_jalr: begin
                // link value pc + 4
                op_a = id_pc;
                op_b = XLEN'(4);
            end
            rv_isa_pkg::op_lui: begin
                op_a = id_imm;
                op_b = '0;
            end
            rv_isa_pkg::op_auipc: begin
                op_a = id_pc;
                op_b = id_imm;
            end
            rv_isa_pkg::op_imm: begin
                // shifts read only imm[4:0] as shamt, srai flag above it is ignored
                op_b = id_imm;
            end
            default: begin
                // register and branch forms keep src2
                op_b = src2;
            end
        endcase
    end

    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    always_comb begin
        case (id_alu_op)
            rv_isa_pkg::alu_add:  alu_result = op_a + op_b;
            rv_isa_pkg::alu_sub:  alu_result = op_a - op_b;
            rv_isa_pkg::alu_and:  alu_result = op_a & op_b;
            rv_isa_pkg::alu_or:   alu_result = op_a | op_b;
            rv_isa_pkg::alu_xor:  alu_result = op_a ^ op_b;
            rv_isa_pkg::alu_slt:  alu_result = {{(XLEN-1){1'b0}}, lt_signed};
            rv_isa_pkg::alu_sltu: alu_result = {{(XLEN-1){1'b0}}, lt_unsigned};
            rv_isa_pkg::alu_sll:  alu_result = op_a << op_b[4:0];
            rv_isa_pkg::alu_srl:  alu_result = op_a >> op_b[4:0];
            rv_isa_pkg::alu_sra:  alu_result = $signed(op_a) >>> op_b[4:0];
            default:              alu_result = '0;
        endcase
    end

    // flags for branch resolution
    assign alu_zero = (alu_result == '0);
    always_comb begin
        case (id_alu_op)
            rv_isa_pkg::alu_slt:  alu_less = lt_signed;
            rv_isa_pkg::alu_sltu: alu_less = lt_unsigned;
            default:              alu_less = 1'b0;
        endcase
    end

endmodule

/* ex_stage/branch_resolve.sv */
module branch_resolve #(
    parameter int XLEN = 32
) (
    input  logic                   accept,
    input  rv_isa_pkg::rv_opcode_e id_opcode,
    input  logic [2:0]             id_func3,
    input  logic [XLEN-1:0]        id_pc,
    input  logic [XLEN-1:0]        id_imm,
    input  logic [XLEN-1:0]        src1,
    input  logic                   alu_zero,
    input  logic                   alu_less,
    input  logic                   id_predict_taken,
    input  logic [XLEN-1:0]        id_predict_target,
    output logic                   ex_flush,
    output logic [XLEN-1:0]        ex_flush_pc,
    output logic                   bpu_update,
    output logic [XLEN-1:0]        bpu_pc,
    output logic                   bpu_taken,
    output logic [XLEN-1:0]        bpu_target,
    output logic                   bpu_correct
);

    logic            is_branch;
    logic            is_jalr;
    logic            cond_true;
    logic            taken;
    logic [XLEN-1:0] seq_pc;
    logic [XLEN-1:0] br_target;
    logic [XLEN-1:0] jalr_target;
    logic [XLEN-1:0] target;
    logic            pred_match;

    assign is_branch = (id_opcode == rv_isa_pkg::op_branch);
    assign is_jalr   = (id_opcode == rv_isa_pkg::op_jalr);

    // condition from alu flags
    always_comb begin
        case (rv_isa_pkg::branch_cond_e'(id_func3))
            rv_isa_pkg::br_beq:  cond_true = alu_zero;
            rv_isa_pkg::br_bne:  cond_true = !alu_zero;
            rv_isa_pkg::br_blt:  cond_true = alu_less;
            rv_isa_pkg::br_bltu: cond_true = alu_less;
            rv_isa_pkg::br_bge:  cond_true = !alu_less;
            rv_isa_pkg::br_bgeu: cond_true = !alu_less;
            default:             cond_true = 1'b0;
        endcase
    end

    assign seq_pc      = id_pc + XLEN'(4);
    assign br_target   = id_pc + id_imm;
    // jalr drops bit 0 of the sum
    assign jalr_target = (src1 + id_imm) & ~XLEN'(1);

    assign taken  = is_jalr || (is_branch && cond_true);
    assign target = is_jalr ? jalr_target : br_target;

    // taken needs matching target, not taken needs fall-through
    assign pred_match = (id_predict_taken == taken)
                        && (id_predict_target == (taken ? target : seq_pc));

    // jal and non-control instructions always count as correct
    assign bpu_correct = !(is_branch || is_jalr) || pred_match;

    // strobes only in the acceptance cycle
    assign ex_flush    = accept && !bpu_correct;
    assign ex_flush_pc = taken ? target : seq_pc;
    assign bpu_update  = accept && taken;

    assign bpu_pc     = id_pc;
    assign bpu_taken  = taken;
    assign bpu_target = target;

endmodule

/* ex_stage/ex_lsu_reg.sv */
module ex_lsu_reg #(
    parameter int XLEN = 32
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   id_valid,
    input  logic                   lsu_ready,
    input  logic                   load_use,
    input  rv_isa_pkg::rv_opcode_e id_opcode,
    input  logic [2:0]             id_func3,
    input  logic [XLEN-1:0]        id_pc,
    input  ex_pipe_pkg::reg_idx_t  id_rd,
    input  logic                   id_reg_write,
    input  logic [XLEN-1:0]        alu_result,
    input  logic [XLEN-1:0]        src2,
    output logic                   ex_ready,
    output logic                   accept,
    output logic                   ex_lsu_valid,
    output logic [XLEN-1:0]        ex_lsu_pc,
    output logic [XLEN-1:0]        ex_lsu_result,
    output logic [XLEN-1:0]        ex_lsu_store_data,
    output ex_pipe_pkg::reg_idx_t  ex_lsu_rd,
    output logic                   ex_lsu_reg_write,
    output logic                   ex_lsu_mem_read,
    output logic                   ex_lsu_mem_write,
    output logic [2:0]             ex_lsu_mem_len
);

    // slot free or draining this cycle, and no hazard
    assign ex_ready = (lsu_ready || !ex_lsu_valid) && !load_use;
    assign accept   = id_valid && ex_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_lsu_valid <= 1'b0;
        end else if (accept) begin
            ex_lsu_valid <= 1'b1;
        end else if (lsu_ready) begin
            // item taken, nothing new behind it
            ex_lsu_valid <= 1'b0;
        end
    end

    // control fields
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_lsu_reg_write <= 1'b0;
            ex_lsu_mem_read  <= 1'b0;
            ex_lsu_mem_write <= 1'b0;
        end else if (accept) begin
            ex_lsu_reg_write <= id_reg_write;
            ex_lsu_mem_read  <= (id_opcode == rv_isa_pkg::op_load);
            ex_lsu_mem_write <= (id_opcode == rv_isa_pkg::op_store);
        end
    end

    // payload, held under back-pressure
    always_ff @(posedge clk) begin
        if (accept) begin
            ex_lsu_pc         <= id_pc;
            ex_lsu_result     <= alu_result;
            ex_lsu_store_data <= src2;
            ex_lsu_rd         <= id_rd;
            ex_lsu_mem_len    <= id_func3;
        end
    end

endmodule

/* ex_stage/ex_stage.sv */
module ex_stage #(
    parameter int XLEN = 32
) (
    input  logic                   clk,
    input  logic                   reset,
    // decode side
    input  logic                   id_valid,
    output logic                   ex_ready,
    input  logic [XLEN-1:0]        id_pc,
    input  logic [XLEN-1:0]        id_imm,
    input  rv_isa_pkg::rv_opcode_e id_opcode,
    input  logic [2:0]             id_func3,
    input  rv_isa_pkg::alu_op_e    id_alu_op,
    input  ex_pipe_pkg::reg_idx_t  id_rd,
    input  ex_pipe_pkg::reg_idx_t  id_rs1,
    input  ex_pipe_pkg::reg_idx_t  id_rs2,
    input  logic                   id_reg_write,
    input  logic [XLEN-1:0]        rf_rs1_data,
    input  logic [XLEN-1:0]        rf_rs2_data,
    input  logic                   id_predict_taken,
    input  logic [XLEN-1:0]        id_predict_target,
    // memory side
    input  logic                   lsu_ready,
    output logic                   ex_lsu_valid,
    output logic [XLEN-1:0]        ex_lsu_pc,
    output logic [XLEN-1:0]        ex_lsu_result,
    output logic [XLEN-1:0]        ex_lsu_store_data,
    output ex_pipe_pkg::reg_idx_t  ex_lsu_rd,
    output logic                   ex_lsu_reg_write,
    output logic                   ex_lsu_mem_read,
    output logic                   ex_lsu_mem_write,
    output logic [2:0]             ex_lsu_mem_len,
    // write-back and pending loads
    input  logic                   lsu_wb_valid,
    input  logic                   lsu_wb_reg_write,
    input  ex_pipe_pkg::reg_idx_t  lsu_wb_rd,
    input  logic [XLEN-1:0]        lsu_wb_data,
    input  logic                   lsu_load_pending,
    input  ex_pipe_pkg::reg_idx_t  lsu_load_rd,
    // fetch side
    output logic                   ex_flush,
    output logic [XLEN-1:0]        ex_flush_pc,
    output logic                   bpu_update,
    output logic [XLEN-1:0]        bpu_pc,
    output logic                   bpu_taken,
    output logic [XLEN-1:0]        bpu_target,
    output logic                   bpu_correct
);

    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic            load_use;
    logic [XLEN-1:0] alu_result;
    logic            alu_zero;
    logic            alu_less;
    logic            accept;

    operand_forward #(.XLEN(XLEN)) u_operand_forward (
        .id_rs1           (id_rs1),
        .id_rs2           (id_rs2),
        .rf_rs1_data      (rf_rs1_data),
        .rf_rs2_data      (rf_rs2_data),
        .ex_lsu_valid     (ex_lsu_valid),
        .ex_lsu_reg_write (ex_lsu_reg_write),
        .ex_lsu_mem_read  (ex_lsu_mem_read),
        .ex_lsu_rd        (ex_lsu_rd),
        .ex_lsu_result    (ex_lsu_result),
        .lsu_wb_valid     (lsu_wb_valid),
        .lsu_wb_reg_write (lsu_wb_reg_write),
        .lsu_wb_rd        (lsu_wb_rd),
        .lsu_wb_data      (lsu_wb_data),
        .lsu_load_pending (lsu_load_pending),
        .lsu_load_rd      (lsu_load_rd),
        .src1             (src1),
        .src2             (src2),
        .load_use         (load_use)
    );

    alu #(.XLEN(XLEN)) u_alu (
        .id_opcode  (id_opcode),
        .id_alu_op  (id_alu_op),
        .id_pc      (id_pc),
        .id_imm     (id_imm),
        .src1       (src1),
        .src2       (src2),
        .alu_result (alu_result),
        .alu_zero   (alu_zero),
        .alu_less   (alu_less)
    );

    branch_resolve #(.XLEN(XLEN)) u_branch_resolve (
        .accept            (accept),
        .id_opcode         (id_opcode),
        .id_func3          (id_func3),
        .id_pc             (id_pc),
        .id_imm            (id_imm),
        .src1              (src1),
        .alu_zero          (alu_zero),
        .alu_less          (alu_less),
        .id_predict_taken  (id_predict_taken),
        .id_predict_target (id_predict_target),
        .ex_flush          (ex_flush),
        .ex_flush_pc       (ex_flush_pc),
        .bpu_update        (bpu_update),
        .bpu_pc            (bpu_pc),
        .bpu_taken         (bpu_taken),
        .bpu_target        (bpu_target),
        .bpu_correct       (bpu_correct)
    );

    ex_lsu_reg #(.XLEN(XLEN)) u_ex_lsu_reg (
        .clk               (clk),
        .reset             (reset),
        .id_valid          (id_valid),
        .lsu_ready         (lsu_ready),
        .load_use          (load_use),
        .id_opcode         (id_opcode),
        .id_func3          (id_func3),
        .id_pc             (id_pc),
        .id_rd             (id_rd),
        .id_reg_write      (id_reg_write),
        .alu_result        (alu_result),
        .src2              (src2),
        .ex_ready          (ex_ready),
        .accept            (accept),
        .ex_lsu_valid      (ex_lsu_valid),
        .ex_lsu_pc         (ex_lsu_pc),
        .ex_lsu_result     (ex_lsu_result),
        .ex_lsu_store_data (ex_lsu_store_data),
        .ex_lsu_rd         (ex_lsu_rd),
        .ex_lsu_reg_write  (ex_lsu_reg_write),
        .ex_lsu_mem_read   (ex_lsu_mem_read),
        .ex_lsu_mem_write  (ex_lsu_mem_write),
        .ex_lsu_mem_len    (ex_lsu_mem_len)
    );

endmodule

/* test/ex_ref_model.svh */
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

// expected alu result from the instruction form and forwarded sources
function automatic logic [31:0] model_alu(input rv_isa_pkg::rv_opcode_e opc,
                                          input rv_isa_pkg::alu_op_e op,
                                          input logic [31:0] pc,
                                          input logic [31:0] imm,
                                          input logic [31:0] s1,
                                          input logic [31:0] s2);
    logic [31:0] a;
    logic [31:0] b;
    a = s1;
    b = s2;
    if (opc == rv_isa_pkg::op_load || opc == rv_isa_pkg::op_store || opc == rv_isa_pkg::op_imm)
        b = imm;
    // link address
    if (opc == rv_isa_pkg::op_jal || opc == rv_isa_pkg::op_jalr) begin
        a = pc;
        b = 32'd4;
    end
    if (opc == rv_isa_pkg::op_lui) begin
        a = imm;
        b = 32'd0;
    end
    if (opc == rv_isa_pkg::op_auipc) begin
        a = pc;
        b = imm;
    end
    case (op)
        rv_isa_pkg::alu_add:  return a + b;
        rv_isa_pkg::alu_sub:  return a - b;
        rv_isa_pkg::alu_and:  return a & b;
        rv_isa_pkg::alu_or:   return a | b;
        rv_isa_pkg::alu_xor:  return a ^ b;
        rv_isa_pkg::alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        rv_isa_pkg::alu_sltu: return (a < b) ? 32'd1 : 32'd0;
        rv_isa_pkg::alu_sll:  return a << b[4:0];
        rv_isa_pkg::alu_srl:  return a >> b[4:0];
        rv_isa_pkg::alu_sra:  return $signed(a) >>> b[4:0];
        default:              return 32'd0;
    endcase
endfunction

// branch condition straight from the func3 encoding
function automatic logic model_cond(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
    case (f3)
        3'b000:  return a == b;
        3'b001:  return a != b;
        3'b100:  return $signed(a) < $signed(b);
        3'b101:  return $signed(a) >= $signed(b);
        3'b110:  return a < b;
        3'b111:  return a >= b;
        default: return 1'b0;
    endcase
endfunction

`endif

/* test/tb_ex_stage.sv */
`include "ex_ref_model.svh"

module tb_ex_stage;

    logic clk = 1'b0;
    logic reset;
    logic id_valid, ex_ready, id_reg_write, id_predict_taken, lsu_ready;
    logic [31:0] id_pc, id_imm, rf_rs1_data, rf_rs2_data, id_predict_target;
    rv_isa_pkg::rv_opcode_e id_opcode;
    rv_isa_pkg::alu_op_e id_alu_op;
    logic [2:0] id_func3, ex_lsu_mem_len;
    ex_pipe_pkg::reg_idx_t id_rd, id_rs1, id_rs2, ex_lsu_rd, lsu_wb_rd, lsu_load_rd;
    logic ex_lsu_valid, ex_lsu_reg_write, ex_lsu_mem_read, ex_lsu_mem_write;
    logic [31:0] ex_lsu_pc, ex_lsu_result, ex_lsu_store_data, lsu_wb_data;
    logic lsu_wb_valid, lsu_wb_reg_write, lsu_load_pending;
    logic ex_flush, bpu_update, bpu_taken, bpu_correct;
    logic [31:0] ex_flush_pc, bpu_pc, bpu_target;

    // model state mirroring the execute/memory register
    logic m_valid, m_load, m_wr;
    ex_pipe_pkg::reg_idx_t m_rd;
    logic [31:0] m_res, rng_state, e1, e2, exp_res, chk_res, tgt;
    logic [107:0] snap;
    logic after_reset, hold_prev, chk_pending, elu, acc, taken, ctrl, correct;
    ex_pipe_pkg::reg_idx_t chk_rd;
    logic [31:0] chk_pc, chk_sd;
    logic chk_wr, chk_mr, chk_mw;
    logic [2:0] chk_len;
    int cycle_count;
    bit accepted;

    ex_stage #(.XLEN(32)) u_dut (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] rand32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_value(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        assert (exp === act) else begin
            $display("Fail %s expected %h actual %h", name, exp, act);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    // forwarding priority on the model side
    function automatic logic [31:0] fwd_value(input ex_pipe_pkg::reg_idx_t idx,
                                              input logic [31:0] rf);
        if (m_valid && m_wr && !m_load && m_rd != 0 && m_rd == idx)
            return m_res;
        if (lsu_wb_valid && lsu_wb_reg_write && lsu_wb_rd != 0 && lsu_wb_rd == idx)
            return lsu_wb_data;
        return rf;
    endfunction

    // memory side changes freely while decode side holds
    task automatic drive_lsu_side();
        logic [31:0] r;
        r = rand32();
        lsu_ready        <= (r[17:16] != 2'b00);
        lsu_wb_valid     <= r[0];
        lsu_wb_reg_write <= r[1];
        lsu_wb_rd        <= {2'b00, r[6:4]};
        lsu_wb_data      <= rand32();
        lsu_load_pending <= (r[11:9] == 3'b000);
        lsu_load_rd      <= {2'b00, r[14:12]};
    endtask

    task automatic drive_instr();
        logic [31:0] r, pc, imm, d1;
        rv_isa_pkg::rv_opcode_e opc;
        rv_isa_pkg::alu_op_e aop;
        logic [2:0] f3;
        r   = rand32();
        pc  = {rand32() & 32'h0000_fffc};
        imm = rand32();
        f3  = r[10:8];
        aop = rv_isa_pkg::alu_add;
        case (r[31:4] % 12)
            0, 1: begin
                opc = rv_isa_pkg::op_reg;
                aop = rv_isa_pkg::alu_op_e'(r[15:12] % 10);
            end
            2, 3: begin
                opc = rv_isa_pkg::op_imm;
                aop = rv_isa_pkg::alu_op_e'(r[15:12] % 10);
                if (aop == rv_isa_pkg::alu_sub)
                    aop = rv_isa_pkg::alu_add;
            end
            4: opc = rv_isa_pkg::op_lui;
            5: opc = rv_isa_pkg::op_auipc;
            6: opc = rv_isa_pkg::op_load;
            7: opc = rv_isa_pkg::op_store;
            8, 9: begin
                opc = rv_isa_pkg::op_branch;
                if (f3 == 3'b010 || f3 == 3'b011)
                    f3 = 3'b000;
                aop = (f3[2:1] == 2'b00) ? rv_isa_pkg::alu_sub :
                      (f3[2:1] == 2'b10) ? rv_isa_pkg::alu_slt : rv_isa_pkg::alu_sltu;
                imm = {{19{r[24]}}, r[24:13], 1'b0};
            end
            10: opc = rv_isa_pkg::op_jalr;
            default: opc = rv_isa_pkg::op_jal;
        endcase
        // x0 reads as zero from the register file
        d1 = (r[2:0] == 0) ? 32'd0 : rand32();
        id_valid     <= 1'b1;
        id_opcode    <= opc;
        id_alu_op    <= aop;
        id_func3     <= f3;
        id_pc        <= pc;
        id_imm       <= imm;
        id_rs1       <= {2'b00, r[2:0]};
        id_rs2       <= {2'b00, r[5:3]};
        id_rd        <= {2'b00, r[28:26]};
        id_reg_write <= (opc != rv_isa_pkg::op_branch) && (opc != rv_isa_pkg::op_store);
        rf_rs1_data  <= d1;
        if (r[5:3] == 0)
            rf_rs2_data <= 32'd0;
        else
            rf_rs2_data <= r[25] ? d1 : rand32();
        id_predict_taken <= r[30];
        case (rand32() % 3)
            0:       id_predict_target <= pc + imm;
            1:       id_predict_target <= pc + 32'd4;
            default: id_predict_target <= (opc == rv_isa_pkg::op_jalr) ? imm & ~32'd1 : rand32();
        endcase
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= 6000) begin
            $display("timeout, the stage stopped accepting instructions");
            $display("Simulation FAILED");
            $fatal(1);
        end
    end

    // checks sampled mid-cycle away from the driving edge
    always @(negedge clk) begin
        if (reset) begin
            check_value("reset_valid", 0, {ex_lsu_valid, ex_flush, bpu_update,
                        ex_lsu_reg_write, ex_lsu_mem_read, ex_lsu_mem_write});
            m_valid = 1'b0;
            after_reset = 1'b1;
            hold_prev = 1'b0;
            chk_pending = 1'b0;
        end else begin
            if (after_reset)
                check_value("after_reset", 0, {ex_lsu_valid, ex_flush, bpu_update,
                            ex_lsu_reg_write, ex_lsu_mem_read, ex_lsu_mem_write});
            after_reset = 1'b0;
            check_value("ex_lsu_valid", m_valid, ex_lsu_valid);
            if (chk_pending) begin
                check_value("ex_lsu_result", chk_res, ex_lsu_result);
                check_value("ex_lsu_rd", chk_rd, ex_lsu_rd);
                check_value("ex_lsu_pc", chk_pc, ex_lsu_pc);
                check_value("ex_lsu_store_data", chk_sd, ex_lsu_store_data);
                check_value("ex_lsu_reg_write", chk_wr, ex_lsu_reg_write);
                check_value("ex_lsu_mem_read", chk_mr, ex_lsu_mem_read);
                check_value("ex_lsu_mem_write", chk_mw, ex_lsu_mem_write);
                check_value("ex_lsu_mem_len", chk_len, ex_lsu_mem_len);
            end
            if (hold_prev)
                check_value("hold_stable", snap, {ex_lsu_valid, ex_lsu_pc, ex_lsu_result,
                            ex_lsu_store_data, ex_lsu_rd, ex_lsu_reg_write, ex_lsu_mem_read,
                            ex_lsu_mem_write, ex_lsu_mem_len});
            e1 = fwd_value(id_rs1, rf_rs1_data);
            e2 = fwd_value(id_rs2, rf_rs2_data);
            elu = (m_valid && m_load && m_rd != 0 && (m_rd == id_rs1 || m_rd == id_rs2))
                  || (lsu_load_pending && lsu_load_rd != 0
                      && (lsu_load_rd == id_rs1 || lsu_load_rd == id_rs2));
            check_value("ex_ready", (lsu_ready || !m_valid) && !elu, ex_ready);
            acc = id_valid && ex_ready;
            exp_res = model_alu(id_opcode, id_alu_op, id_pc, id_imm, e1, e2);
            if (acc) begin
                ctrl = (id_opcode == rv_isa_pkg::op_branch)
                       || (id_opcode == rv_isa_pkg::op_jalr);
                taken = (id_opcode == rv_isa_pkg::op_jalr)
                        || ((id_opcode == rv_isa_pkg::op_branch) && model_cond(id_func3, e1, e2));
                tgt = (id_opcode == rv_isa_pkg::op_jalr) ? ((e1 + id_imm) & ~32'd1)
                                                         : id_pc + id_imm;
                correct = !ctrl || ((id_predict_taken == taken)
                          && (id_predict_target == (taken ? tgt : id_pc + 32'd4)));
                check_value("ex_flush", !correct, ex_flush);
                check_value("bpu_update", ctrl && taken, bpu_update);
                check_value("bpu_correct", correct, bpu_correct);
                check_value("bpu_pc", id_pc, bpu_pc);
                if (ctrl) begin
                    check_value("bpu_taken", taken, bpu_taken);
                    check_value("bpu_target", tgt, bpu_target);
                    check_value("ex_flush_pc", taken ? tgt : id_pc + 32'd4, ex_flush_pc);
                end
            end else begin
                check_value("strobe_idle", 0, {ex_flush, bpu_update});
            end
            hold_prev = ex_lsu_valid && !lsu_ready;
            snap = {ex_lsu_valid, ex_lsu_pc, ex_lsu_result, ex_lsu_store_data, ex_lsu_rd,
                    ex_lsu_reg_write, ex_lsu_mem_read, ex_lsu_mem_write, ex_lsu_mem_len};
            chk_pending = acc;
            chk_res = exp_res;
            chk_rd = id_rd;
            chk_pc = id_pc;
            chk_sd = e2;
            chk_wr = id_reg_write;
            chk_mr = (id_opcode == rv_isa_pkg::op_load);
            chk_mw = (id_opcode == rv_isa_pkg::op_store);
            chk_len = id_func3;
            // next state of the register as the coming edge loads it
            if (acc) begin
                m_valid = 1'b1;
                m_rd = id_rd;
                m_res = exp_res;
                m_wr = id_reg_write;
                m_load = (id_opcode == rv_isa_pkg::op_load);
            end else if (lsu_ready) begin
                m_valid = 1'b0;
            end
        end
    end

    initial begin
        rng_state = 32'd84109;
        cycle_count = 0;
        reset = 1'b1;
        id_valid = 1'b0;
        id_pc = 0;
        id_imm = 0;
        id_opcode = rv_isa_pkg::op_imm;
        id_alu_op = rv_isa_pkg::alu_add;
        id_func3 = 0;
        id_rd = 0;
        id_rs1 = 0;
        id_rs2 = 0;
        id_reg_write = 0;
        rf_rs1_data = 0;
        rf_rs2_data = 0;
        id_predict_taken = 0;
        id_predict_target = 0;
        lsu_ready = 1'b1;
        lsu_wb_valid = 0;
        lsu_wb_reg_write = 0;
        lsu_wb_rd = 0;
        lsu_wb_data = 0;
        lsu_load_pending = 0;
        lsu_load_rd = 0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        for (int n = 0; n < 700; n++) begin
            @(posedge clk);
            // an occasional bubble lets the register drain
            if (rand32() % 8 == 0) begin
                id_valid <= 1'b0;
                drive_lsu_side();
                @(posedge clk);
            end
            drive_instr();
            drive_lsu_side();
            accepted = 0;
            while (!accepted) begin
                @(negedge clk);
                accepted = ex_ready;
                if (!accepted) begin
                    @(posedge clk);
                    drive_lsu_side();
                end
            end
        end
        @(posedge clk);
        id_valid <= 1'b0;
        lsu_ready <= 1'b1;
        repeat (3) @(posedge clk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* tb.f */
+incdir+test
common/rv_isa_pkg.sv
common/ex_pipe_pkg.sv
ex_stage/operand_forward.sv
ex_stage/alu.sv
ex_stage/branch_resolve.sv
ex_stage/ex_lsu_reg.sv
ex_stage/ex_stage.sv
test/tb_ex_stage.sv
